/* project.f */
+incdir+logic
+incdir+tests
logic/shift_pkg.sv
logic/shift_count_stage.sv
logic/shift_core.sv
logic/shift_flag_stage.sv
logic/shift_unit.sv
tests/tb_shift_unit.sv

/* tests/shift_ref_model.svh */
//**************************************************************************
// Shift unit reference model
// Bit-by-bit x86 shift model with flags, and the Galois LFSR step
//**************************************************************************

`ifndef SHIFT_REF_MODEL_SVH
`define SHIFT_REF_MODEL_SVH

// Galois LFSR step, polynomial x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic [31:0] next;
  next = state >> 1;
  if (state[0]) begin
    next = next ^ 32'h8020_0003;
  end
  return next;
endfunction

// Set when the byte holds an even number of ones
function automatic logic even_parity(input logic [7:0] b);
  int ones;
  int i;
  ones = 0;
  for (i = 0; i < 8; i++) begin
    if (b[i]) ones++;
  end
  return (ones % 2) == 0;
endfunction

// Expected result for one request
function automatic shift_pkg::shift_res_t expected_result(input shift_pkg::shift_req_t req);
  int                    c;
  int                    w;
  int                    i;
  logic [15:0]           src;
  logic [15:0]           res;
  logic                  cf;
  logic                  of;
  logic                  sign;
  shift_pkg::shift_res_t r;
  c = int'(req.count[`SHIFT_MASK_W-1:0]);
  w = req.word_op ? 16 : 8;
  // Masked count of zero leaves value and flags alone
  if (c == 0) begin
    r.value = req.operand;
    r.flags = req.flags_in;
    return r;
  end
  src  = req.word_op ? req.operand : {8'h00, req.operand[7:0]};
  sign = src[w-1];
  res  = '0;
  cf   = 1'b0;
  of   = 1'b0;
  case (req.op)
    shift_pkg::OP_SHL: begin
      for (i = 0; i < w; i++) begin
        if (i >= c) res[i] = src[i-c];
      end
      // Last bit out, nothing left once the count passes the width
      if (c <= w) cf = src[w-c];
      of = res[w-1] ^ cf;
    end
    shift_pkg::OP_SHR: begin
      for (i = 0; i < w; i++) begin
        if (i + c < w) res[i] = src[i+c];
      end
      if (c <= w) cf = src[c-1];
      of = sign;
    end
    default: begin
      // SAR fills from the sign
      for (i = 0; i < w; i++) begin
        res[i] = (i + c < w) ? src[i+c] : sign;
      end
      if (c >= w) cf = sign;
      else cf = src[c-1];
      of = 1'b0;
    end
  endcase
  // Byte SAR carries the sign into the upper byte
  if (!req.word_op && req.op == shift_pkg::OP_SAR) begin
    res[15:8] = {8{res[7]}};
  end
  r.value    = res;
  r.flags.cf = cf;
  r.flags.of = of;
  r.flags.sf = res[w-1];
  r.flags.zf = req.word_op ? (res == 16'h0000) : (res[7:0] == 8'h00);
  r.flags.pf = even_parity(res[7:0]);
  return r;
endfunction

`endif

/* tests/tb_shift_unit.sv */
//**************************************************************************
// Shift unit testbench
// Random and directed shifts checked against a bit-level model, with
// reset, zero-count, flag and back-to-back pipeline tests
//**************************************************************************

`timescale 1ns/10ps

`include "shift_defines.svh"

module tb_shift_unit;

  // Request counts per test
  localparam int WORD_REQS    = 150;
  localparam int BYTE_REQS    = 150;
  localparam int ZERO_REQS    = 24;
  localparam int FLAG_REQS    = 9;
  localparam int PIPE_REQS    = 64;
  localparam int TOTAL_REQS   = WORD_REQS + BYTE_REQS + ZERO_REQS + FLAG_REQS + PIPE_REQS;
  localparam int NUM_TESTS    = 6;
  localparam int RESET_CYCLES = 4;
  localparam int IDLE_CYCLES  = 8;
  localparam int DRIVE_DELAY  = 1;
  // Limit covers requests, per-test drain, reset and idle time and a margin of 20
  localparam int CYCLE_LIMIT  = TOTAL_REQS + NUM_TESTS * (`SHIFT_LATENCY + 3) +
                                RESET_CYCLES + IDLE_CYCLES + 20;

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid;
  shift_pkg::shift_req_t in_req;
  logic                  out_valid;
  shift_pkg::shift_res_t out_res;

  // Scoreboard state
  shift_pkg::shift_res_t expected_q[$];
  shift_pkg::shift_res_t exp_res;
  logic [31:0]           lfsr_state = 32'd70635;
  int                    cycle_count = 0;
  int                    errors = 0;
  int                    sent = 0;
  int                    received = 0;
  int                    tests_run = 0;
  int                    tests_failed = 0;
  // Per-test bookkeeping
  int                    test_err_start;
  int                    test_tx;
  int                    test_rx;
  int                    first_out;
  int                    last_out;
  int                    i;

  `include "shift_ref_model.svh"

  shift_unit UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_res   (out_res)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //************************************************************************
  // Random source and request builders
  //************************************************************************

  // One LFSR step per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    int          k;
    r = '0;
    for (k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic shift_pkg::shift_op_e random_op();
    logic [31:0] b;
    b = random_bits(2);
    while (b[1:0] == 2'd3) b = random_bits(2);
    case (b[1:0])
      2'd0:    return shift_pkg::OP_SHL;
      2'd1:    return shift_pkg::OP_SAR;
      default: return shift_pkg::OP_SHR;
    endcase
  endfunction

  // Nonzero masked count with optionally random upper count bits
  function automatic shift_pkg::shift_req_t random_req(input logic word, input logic wide);
    shift_pkg::shift_req_t r;
    logic [31:0]           b;
    b           = random_bits(16);
    r.operand   = b[15:0];
    r.op        = random_op();
    r.word_op   = word;
    b           = random_bits(5);
    if (b[4:0] == 5'd0) b[4:0] = 5'd1;
    r.count     = {3'b000, b[4:0]};
    if (wide) begin
      b = random_bits(3);
      r.count[7:5] = b[2:0];
    end
    b           = random_bits(5);
    r.flags_in  = b[4:0];
    return r;
  endfunction

  //************************************************************************
  // Compare tasks
  //************************************************************************

  task automatic check_value(input string name, input logic [15:0] act, input logic [15:0] exp);
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_flags(input string name, input shift_pkg::shift_flags_t act,
                             input shift_pkg::shift_flags_t exp);
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s got %b expected %b (cf of sf zf pf)", $time, name, act, exp);
    end
  endtask

  //************************************************************************
  // Driving and test framing
  //************************************************************************

  task automatic send_req(input shift_pkg::shift_req_t req);
    @(posedge clk);
    #DRIVE_DELAY;
    in_valid = 1'b1;
    in_req   = req;
    expected_q.push_back(expected_result(req));
    sent++;
    test_tx++;
  endtask

  task automatic send_fixed(input logic [15:0] operand, input shift_pkg::shift_op_e op,
                            input logic word, input logic [7:0] count);
    shift_pkg::shift_req_t r;
    logic [31:0]           b;
    b          = random_bits(5);
    r.operand  = operand;
    r.op       = op;
    r.word_op  = word;
    r.count    = count;
    r.flags_in = b[4:0];
    send_req(r);
  endtask

  // Drop the strobe, then wait for every pending result
  task automatic drain();
    @(posedge clk);
    #DRIVE_DELAY;
    in_valid = 1'b0;
    in_req   = '0;
    while (expected_q.size() != 0) @(posedge clk);
  endtask

  task automatic start_test();
    test_err_start = errors;
    test_tx        = 0;
    test_rx        = 0;
    first_out      = -1;
    last_out       = -1;
  endtask

  task automatic finish_test(input string name);
    int bad;
    bad = errors - test_err_start;
    tests_run++;
    if (bad != 0) tests_failed++;
    $display("test %-12s sent %0d received %0d errors %0d -> %s",
             name, test_tx, test_rx, bad, (bad == 0) ? "ok" : "FAIL");
  endtask

  //************************************************************************
  // Output monitor and timeout
  //************************************************************************

  // Outputs change on the rising edge and are sampled on the falling edge
  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      if (expected_q.size() == 0) begin
        errors++;
        $display("unexpected result at %0t with no request pending", $time);
      end else begin
        exp_res = expected_q.pop_front();
        check_value("out_res.value", out_res.value, exp_res.value);
        check_flags("out_res.flags", out_res.flags, exp_res.flags);
      end
      received++;
      test_rx++;
      if (first_out < 0) first_out = cycle_count;
      last_out = cycle_count;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("run timed out after %0d cycles with %0d results pending",
               cycle_count, expected_q.size());
      $display("Simulation failed");
      $finish;
    end
  end

  //************************************************************************
  // Test sequence
  //************************************************************************

  initial begin
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_req   = '0;

    // out_valid must stay quiet during and after reset
    start_test();
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (out_valid !== 1'b0) begin
        errors++;
        $display("out_valid was high during reset at %0t", $time);
      end
    end
    rst_n = 1'b1;
    repeat (IDLE_CYCLES) begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (out_valid !== 1'b0) begin
        errors++;
        $display("out_valid was high at %0t before any request", $time);
      end
    end
    finish_test("reset");

    start_test();
    for (i = 0; i < WORD_REQS; i++) send_req(random_req(1'b1, 1'b0));
    drain();
    finish_test("word");

    start_test();
    for (i = 0; i < BYTE_REQS; i++) send_req(random_req(1'b0, 1'b1));
    drain();
    finish_test("byte");

    // Every multiple of 32 masks to zero
    start_test();
    for (i = 0; i < ZERO_REQS; i++) begin
      send_fixed(16'(random_bits(16)), (i % 3 == 0) ? shift_pkg::OP_SHL :
                 (i % 3 == 1) ? shift_pkg::OP_SAR : shift_pkg::OP_SHR,
                 i[0], 8'((i / 3) * 32));
    end
    drain();
    finish_test("zero_count");

    // Zero results and known parity at both widths
    start_test();
    send_fixed(16'h8000, shift_pkg::OP_SHL, 1'b1, 8'd1);
    send_fixed(16'h3480, shift_pkg::OP_SHL, 1'b0, 8'd1);
    send_fixed(16'h0001, shift_pkg::OP_SHR, 1'b1, 8'd1);
    send_fixed(16'h00ff, shift_pkg::OP_SHR, 1'b0, 8'd4);
    send_fixed(16'h0700, shift_pkg::OP_SHR, 1'b1, 8'd8);
    send_fixed(16'hff00, shift_pkg::OP_SAR, 1'b1, 8'd8);
    send_fixed(16'h00c0, shift_pkg::OP_SAR, 1'b0, 8'd1);
    send_fixed(16'h1234, shift_pkg::OP_SHL, 1'b1, 8'd16);
    send_fixed(16'h5503, shift_pkg::OP_SHL, 1'b0, 8'd2);
    drain();
    finish_test("flags");

    // Back-to-back requests must leave on consecutive cycles
    start_test();
    for (i = 0; i < PIPE_REQS; i++) send_req(random_req(1'(random_bits(1)), 1'b1));
    drain();
    if (test_rx != PIPE_REQS || last_out - first_out + 1 != PIPE_REQS) begin
      errors++;
      $display("pipeline lost its rhythm: %0d results over %0d cycles for %0d requests",
               test_rx, last_out - first_out + 1, PIPE_REQS);
    end
    finish_test("pipeline");

    if (received != sent) begin
      errors++;
      $display("received %0d results for %0d requests sent", received, sent);
    end
    $display("tests %0d failed %0d sent %0d received %0d errors %0d",
             tests_run, tests_failed, sent, received, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* logic/shift_unit.sv */
//**************************************************************************
// Shift execution unit
// Three-stage pipeline of count mask, shift core and flag merge
//**************************************************************************

`timescale 1ns/10ps

module shift_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  shift_pkg::shift_req_t in_req,
  output logic                  out_valid,
  output shift_pkg::shift_res_t out_res
);

  // Stage 1 to stage 2
  logic                   cnt_valid;
  shift_pkg::shift_cnt_t  cnt_data;

  // Stage 2 to stage 3
  logic                   core_valid;
  shift_pkg::shift_core_t core_data;

  // Count mask and zero-count detect
  shift_count_stage u_count (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .cnt_valid (cnt_valid),
    .cnt_data  (cnt_data)
  );

  // Shifters, CF and OF
  shift_core u_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .cnt_valid  (cnt_valid),
    .cnt_data   (cnt_data),
    .core_valid (core_valid),
    .core_data  (core_data)
  );

  // SF, ZF, PF and final merge
  shift_flag_stage u_flags (
    .clk        (clk),
    .rst_n      (rst_n),
    .core_valid (core_valid),
    .core_data  (core_data),
    .out_valid  (out_valid),
    .out_res    (out_res)
  );

endmodule

/* logic/shift_flag_stage.sv */
//**************************************************************************
// Shift flag stage
// Derives SF, ZF and PF, merges them with CF and OF or keeps the input
// flags on a zero count, and registers the final result
//**************************************************************************

`timescale 1ns/10ps

module shift_flag_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   core_valid,
  input  shift_pkg::shift_core_t core_data,
  output logic                   out_valid,
  output shift_pkg::shift_res_t  out_res
);

  // Low byte feeds PF and the byte ZF
  logic [7:0]              low_byte;
  logic                    sf;
  logic                    zf;
  logic                    pf;
  shift_pkg::shift_flags_t new_flags;
  shift_pkg::shift_res_t   res_next;

  //************************************************************************
  // Result flags
  //************************************************************************

  assign low_byte = core_data.value[7:0];

  // Sign at the selected width
  assign sf = core_data.word_op ? core_data.value[15] : core_data.value[7];

  // Zero test ignores the upper byte for byte operations
  assign zf = core_data.word_op ? (core_data.value == '0) : (low_byte == 8'h00);

  // Even parity of the low byte only, as on x86
  assign pf = ~^low_byte;

  always_comb begin
    new_flags.cf = core_data.cf;
    new_flags.of = core_data.of;
    new_flags.sf = sf;
    new_flags.zf = zf;
    new_flags.pf = pf;
  end

  // Zero count leaves every flag untouched
  always_comb begin
    res_next.value = core_data.value;
    res_next.flags = core_data.zero_count ? core_data.flags_in : new_flags;
  end

  //************************************************************************
  // Output registers
  //************************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= core_valid;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_res <= '0;
    end else if (core_valid) begin
      out_res <= res_next;
    end
  end

  // Byte shift from the core: SHL/SHR clear the upper byte, SAR sign-fills
  a_byte_upper: assert property (
    @(posedge clk) disable iff (!rst_n)
    (core_valid && !core_data.word_op && !core_data.zero_count) |->
      (core_data.value[15:8] == 8'h00) ||
      (core_data.value[7] && core_data.value[15:8] == 8'hff)
  );

endmodule

/* logic/shift_core.sv */
//**************************************************************************
// Shift core
// Byte and word SHL/SAL, SAR and SHR with CF and OF, one register stage
//**************************************************************************

`timescale 1ns/10ps

`include "shift_defines.svh"

module shift_core (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cnt_valid,
  input  shift_pkg::shift_cnt_t  cnt_data,
  output logic                   core_valid,
  output shift_pkg::shift_core_t core_data
);

  // Shift results with the carry bit attached
  // SHL keeps CF on top and the right shifts keep it at bit 0
  logic [`SHIFT_WORD_W:0]   shl16;
  logic [`SHIFT_WORD_W:0]   shr16;
  logic [`SHIFT_WORD_W:0]   sar16;
  logic [8:0]               shl8;
  logic [8:0]               shr8;
  logic [8:0]               sar8;

  // Selected result and flags
  logic [`SHIFT_WORD_W-1:0] shift_val;
  logic                     shift_cf;
  logic                     shift_of;
  logic                     res_msb;
  logic                     src_msb;
  shift_pkg::shift_core_t   core_next;

  //************************************************************************
  // Raw shifters
  //************************************************************************

  // Counts past 16 drain the word shifters to zero
  assign shl16 = {1'b0, cnt_data.operand} << cnt_data.count;
  assign shr16 = {cnt_data.operand, 1'b0} >> cnt_data.count;
  // Sign fill covers counts of 16 and more and CF becomes the sign
  assign sar16 = $signed({cnt_data.operand, 1'b0}) >>> cnt_data.count;

  // Byte width on the low operand byte
  assign shl8 = {1'b0, cnt_data.operand[7:0]} << cnt_data.count;
  assign shr8 = {cnt_data.operand[7:0], 1'b0} >> cnt_data.count;
  assign sar8 = $signed({cnt_data.operand[7:0], 1'b0}) >>> cnt_data.count;

  //************************************************************************
  // Result and CF select
  //************************************************************************

  always_comb begin
    shift_val = cnt_data.operand;
    shift_cf  = 1'b0;
    case (cnt_data.op)
      shift_pkg::OP_SHL: begin
        shift_val = cnt_data.word_op ? shl16[15:0] : {8'h00, shl8[7:0]};
        shift_cf  = cnt_data.word_op ? shl16[16] : shl8[8];
      end
      shift_pkg::OP_SAR: begin
        // Byte SAR sign-extends the result byte
        shift_val = cnt_data.word_op ? sar16[16:1] : {{8{sar8[8]}}, sar8[8:1]};
        shift_cf  = cnt_data.word_op ? sar16[0] : sar8[0];
      end
      shift_pkg::OP_SHR: begin
        shift_val = cnt_data.word_op ? shr16[16:1] : {8'h00, shr8[8:1]};
        shift_cf  = cnt_data.word_op ? shr16[0] : shr8[0];
      end
      default: begin
        shift_val = cnt_data.operand;
        shift_cf  = 1'b0;
      end
    endcase
  end

  // Top bits at the selected width
  assign res_msb = cnt_data.word_op ? shift_val[15] : shift_val[7];
  assign src_msb = cnt_data.word_op ? cnt_data.operand[15] : cnt_data.operand[7];

  // OF per opcode
  always_comb begin
    case (cnt_data.op)
      shift_pkg::OP_SHL: shift_of = res_msb ^ shift_cf;
      shift_pkg::OP_SHR: shift_of = src_msb;
      default:           shift_of = 1'b0;
    endcase
  end

  // Zero count passes the operand and leaves CF and OF unused downstream
  always_comb begin
    core_next.value      = cnt_data.zero_count ? cnt_data.operand : shift_val;
    core_next.word_op    = cnt_data.word_op;
    core_next.zero_count = cnt_data.zero_count;
    core_next.cf         = shift_cf;
    core_next.of         = shift_of;
    core_next.flags_in   = cnt_data.flags_in;
  end

  //************************************************************************
  // Stage registers
  //************************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_valid <= 1'b0;
    end else begin
      core_valid <= cnt_valid;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_data <= '0;
    end else if (cnt_valid) begin
      core_data <= core_next;
    end
  end

  // A logical right shift by a nonzero count clears the top bit
  a_shr_msb_clear: assert property (
    @(posedge clk) disable iff (!rst_n)
    (cnt_valid && !cnt_data.zero_count && cnt_data.op == shift_pkg::OP_SHR) |->
      !res_msb
  );

endmodule

/* logic/shift_count_stage.sv */
//**************************************************************************
// Shift count stage
// Applies the x86 count mask, flags a zero count and registers the
// request for the shift core
//**************************************************************************

`timescale 1ns/10ps

`include "shift_defines.svh"

module shift_count_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  shift_pkg::shift_req_t  in_req,
  output logic                   cnt_valid,
  output shift_pkg::shift_cnt_t  cnt_data
);

  // Masked count and its zero test
  logic [`SHIFT_MASK_W-1:0] masked_count;
  logic                     zero_count;
  shift_pkg::shift_cnt_t    cnt_next;

  //************************************************************************
  // Count mask
  //************************************************************************

  // Only the low 5 bits count, so 32 and 224 act as zero
  assign masked_count = in_req.count[`SHIFT_MASK_W-1:0];

  // Single place where a zero count is detected
  assign zero_count = (masked_count == '0);

  // Repack the request for stage 2
  always_comb begin
    cnt_next.operand    = in_req.operand;
    cnt_next.count      = masked_count;
    cnt_next.op         = in_req.op;
    cnt_next.word_op    = in_req.word_op;
    cnt_next.flags_in   = in_req.flags_in;
    cnt_next.zero_count = zero_count;
  end

  //************************************************************************
  // Stage registers
  //************************************************************************

  // Valid strobe, one per accepted request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_valid <= 1'b0;
    end else begin
      cnt_valid <= in_valid;
    end
  end

  // Payload loads only on a strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_data <= '0;
    end else if (in_valid) begin
      cnt_data <= cnt_next;
    end
  end

  // Decoder never issues the unused opcode
  a_op_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
    in_valid |-> in_req.op inside {shift_pkg::OP_SHL, shift_pkg::OP_SAR,
                                   shift_pkg::OP_SHR}
  );

endmodule

/* logic/shift_pkg.sv */
//**************************************************************************
// Shift unit types
// Opcode enum plus the request, flag and per-stage payload structs
//**************************************************************************

`include "shift_defines.svh"

package shift_pkg;

  // Opcode encoding, 2'd3 is unused
  typedef enum logic [1:0] {
    OP_SHL = 2'd0,
    OP_SAR = 2'd1,
    OP_SHR = 2'd2
  } shift_op_e;

  // Arithmetic flags, AF not modelled
  typedef struct packed {
    logic cf;
    logic of;
    logic sf;
    logic zf;
    logic pf;
  } shift_flags_t;

  // Request as it enters the unit
  typedef struct packed {
    logic [`SHIFT_WORD_W-1:0]  operand;
    logic [`SHIFT_COUNT_W-1:0] count;
    shift_op_e                 op;
    logic                      word_op;
    shift_flags_t              flags_in;
  } shift_req_t;

  // Count stage to shift core
  typedef struct packed {
    logic [`SHIFT_WORD_W-1:0] operand;
    logic [`SHIFT_MASK_W-1:0] count;
    shift_op_e                op;
    logic                     word_op;
    shift_flags_t             flags_in;
    logic                     zero_count;
  } shift_cnt_t;

  // Shift core to flag stage
  typedef struct packed {
    logic [`SHIFT_WORD_W-1:0] value;
    logic                     word_op;
    logic                     zero_count;
    logic                     cf;
    logic                     of;
    shift_flags_t             flags_in;
  } shift_core_t;

  // Final result
  typedef struct packed {
    logic [`SHIFT_WORD_W-1:0] value;
    shift_flags_t             flags;
  } shift_res_t;

endpackage

/* logic/shift_defines.svh */
//**************************************************************************
// Shift unit widths and latency
// Operand, raw count and masked count widths plus pipeline depth
//**************************************************************************

`ifndef SHIFT_DEFINES_SVH
`define SHIFT_DEFINES_SVH

// Operand width for word operations
`define SHIFT_WORD_W 16

// Raw count as delivered by the decoder
`define SHIFT_COUNT_W 8

// Count bits kept by the x86 count mask
`define SHIFT_MASK_W 5

// Input strobe to output strobe, in cycles
`define SHIFT_LATENCY 3

`endif
